/* Bender.yml */
package:
  name: serial_wb

sources:
  - source/wb_bus_pkg.sv
  - source/serial_wb_pkg.sv
  - source/serial_wb_ctrl.sv
  - source/wb_addr_tracker.sv
  - source/axis_fifo.sv
  - source/wb_ram_slave.sv
  - source/serial_wb_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/serial_wb_tb.sv

/* list.f */
+incdir+sim
source/wb_bus_pkg.sv
source/serial_wb_pkg.sv
source/serial_wb_ctrl.sv
source/wb_addr_tracker.sv
source/axis_fifo.sv
source/wb_ram_slave.sv
source/serial_wb_top.sv
sim/serial_wb_tb.sv

/* sim/serial_wb_tb_table.svh */
`ifndef SERIAL_WB_TB_TABLE_SVH
`define SERIAL_WB_TB_TABLE_SVH

// Columns: opcode, address, count, explicit read data flag,
// write bytes (first beat leftmost), expected read bytes (first beat leftmost)
// Writes longer than 8 beats take LFSR data, reads without the flag use the model memory

localparam int NUM_CMDS = 11;
localparam int ROW_W    = 160;

logic [ROW_W-1:0] cmd_tbl [NUM_CMDS];

task automatic load_table();
	// Fill every address so later reads are defined
	cmd_tbl[0]  = {8'h03, 8'h00, 8'h00, 8'h00, 64'h0, 64'h0};
	// Incrementing write then read back of 8 bytes
	cmd_tbl[1]  = {8'h03, 8'h10, 8'h08, 8'h00, 64'h11_22_33_44_55_66_77_88, 64'h0};
	cmd_tbl[2]  = {8'h02, 8'h10, 8'h08, 8'h01, 64'h0, 64'h11_22_33_44_55_66_77_88};
	// Fixed address, last write wins
	cmd_tbl[3]  = {8'h01, 8'h40, 8'h04, 8'h00, 64'hA1_B2_C3_D4_00_00_00_00, 64'h0};
	cmd_tbl[4]  = {8'h00, 8'h40, 8'h03, 8'h01, 64'h0, 64'hD4_D4_D4_00_00_00_00_00};
	// 256 reads across the wrap
	cmd_tbl[5]  = {8'h02, 8'hF0, 8'h00, 8'h00, 64'h0, 64'h0};
	// Mixed traffic, write over the wrap and read it back
	cmd_tbl[6]  = {8'h03, 8'hFE, 8'h04, 8'h00, 64'h5A_6B_7C_8D_00_00_00_00, 64'h0};
	cmd_tbl[7]  = {8'h02, 8'hFD, 8'h06, 8'h00, 64'h0, 64'h0};
	cmd_tbl[8]  = {8'h00, 8'h11, 8'h02, 8'h01, 64'h0, 64'h22_22_00_00_00_00_00_00};
	cmd_tbl[9]  = {8'h01, 8'h80, 8'h01, 8'h00, 64'hE7_00_00_00_00_00_00_00, 64'h0};
	cmd_tbl[10] = {8'h02, 8'h7F, 8'h03, 8'h00, 64'h0, 64'h0};
endtask

// Header plus one stream byte per beat, summed over the table
function automatic int table_bytes();
	int total;
	int beats;
	total = 0;
	for (int i = 0; i < NUM_CMDS; i++)
	begin
		beats = (cmd_tbl[i][143:136] == 8'h00) ? 256 : int'(cmd_tbl[i][143:136]);
		total += 3 + beats;
	end
	return total;
endfunction

`endif

/* sim/serial_wb_tb.sv */
`default_nettype none

module serial_wb_tb;

logic       clk;
logic       sresetn;
logic       in_tvalid;
logic       in_tready;
logic [7:0] in_tdata;
logic       out_tvalid;
logic       out_tready;
logic [7:0] out_tdata;
logic       bus_hold;

logic [15:0] lfsr_state;
logic [7:0]  model_mem [256];   // Last value written per address
logic [7:0]  exp_q [$];          // Read bytes still to come
logic        in_fire;
int          cycles;
int          cycle_limit;

`include "serial_wb_tb_table.svh"

serial_wb_top i_dut (
	.clk        (clk),
	.sresetn    (sresetn),
	.in_tvalid  (in_tvalid),
	.in_tready  (in_tready),
	.in_tdata   (in_tdata),
	.out_tvalid (out_tvalid),
	.out_tready (out_tready),
	.out_tdata  (out_tdata),
	.bus_hold   (bus_hold)
);

initial
begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_step();
	logic fb;
	fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
	lfsr_state = {lfsr_state[14:0], fb};
	return fb;
endfunction

function automatic logic [7:0] random_byte();
	logic [7:0] b;
	b = '0;
	for (int i = 0; i < 8; i++)
		b = {b[6:0], lfsr_step()};
	return b;
endfunction

task automatic abort_run(input string why);
	$display("%s", why);
	$display("TESTBENCH FAILED");
	$fatal(1);
endtask

task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp)
	begin
		$display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
		abort_run("value mismatch");
	end
endtask

// Checks the read stream once per cycle before the edge
task automatic watch_output();
	if (out_tvalid && out_tready)
	begin
		if (exp_q.size() == 0)
			abort_run("a read byte arrived that no command asked for");
		else
			compare("out_tdata", out_tdata, exp_q.pop_front());
	end
endtask

// Drive on the falling edge and sample the handshakes once settled
task automatic step_cycle(input logic valid, input logic [7:0] data);
	@(negedge clk);
	bus_hold   = lfsr_step();
	out_tready = lfsr_step();
	in_tvalid  = valid;
	in_tdata   = data;
	#1;
	in_fire = in_tvalid && in_tready;
	watch_output();
	cycles++;
	if (cycles > cycle_limit)
		abort_run("timeout, the bridge stopped moving bytes");
endtask

task automatic send_byte(input logic [7:0] data);
	if (lfsr_step())
		step_cycle(1'b0, 8'h00);   // Random gap
	do
		step_cycle(1'b1, data);
	while (!in_fire);
endtask

task automatic run_command(input int idx);
	logic [ROW_W-1:0] row;
	logic [7:0]       a;
	logic [7:0]       d;
	logic [7:0]       wr_q [$];
	int               beats;
	row   = cmd_tbl[idx];
	a     = row[151:144];
	beats = (row[143:136] == 8'h00) ? 256 : int'(row[143:136]);

	send_byte(row[159:152]);
	if (exp_q.size() != 0)
		abort_run("next command was taken before the read data drained");

	for (int k = 0; k < beats; k++)
	begin
		if (row[152])   // Write
		begin
			d = (beats <= 8) ? row[127-8*k -: 8] : random_byte();
			wr_q.push_back(d);
			model_mem[a] = d;
		end
		else if (row[128] && k < 8)
			exp_q.push_back(row[63-8*k -: 8]);
		else
			exp_q.push_back(model_mem[a]);
		if (row[153])
			a = a + 8'd1;   // Wraps at 255
	end

	send_byte(row[151:144]);
	send_byte(row[143:136]);
	while (wr_q.size() != 0)
		send_byte(wr_q.pop_front());
endtask

initial
begin
	sresetn    = 1'b0;
	in_tvalid  = 1'b0;
	in_tdata   = 8'h00;
	out_tready = 1'b0;
	bus_hold   = 1'b0;
	in_fire    = 1'b0;
	lfsr_state = 16'd58596;
	cycles     = 0;
	load_table();
	cycle_limit = table_bytes() * 16 + 200;

	repeat (10) @(posedge clk);
	@(negedge clk);
	sresetn = 1'b1;
	#1;
	compare("in_tready", in_tready, 1'b1);
	compare("out_tvalid", out_tvalid, 1'b0);

	for (int i = 0; i < NUM_CMDS; i++)
		run_command(i);

	// Drain the last read and wait for the controller to go idle
	do
		step_cycle(1'b0, 8'h00);
	while (exp_q.size() != 0 || !in_tready);
	repeat (16) step_cycle(1'b0, 8'h00);   // Nothing more may show up
	compare("out_tvalid", out_tvalid, 1'b0);

	$display("TESTBENCH PASSED");
	$finish;
end

endmodule

`default_nettype wire

/* source/axis_fifo.sv */
`default_nettype none

module axis_fifo #(
	parameter int FIFO_DEPTH = 256
) (
	input  logic              clk,
	input  logic              sresetn,

	input  logic              push,
	input  wb_bus_pkg::data_t push_data,

	input  logic              out_tready,
	output logic              out_tvalid,
	output wb_bus_pkg::data_t out_tdata,

	output logic              empty   // Buffer and output stage both empty
);
import wb_bus_pkg::*;

localparam int PTR_W = $clog2(FIFO_DEPTH);
localparam int CNT_W = PTR_W + 1;
localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

data_t            mem [FIFO_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             buf_empty;
logic             out_load;
logic             pop;
logic             bypass;
logic             wr_en;

assign buf_empty = (count == '0);
assign out_load  = !out_tvalid || out_tready;   // Output stage free this cycle
assign pop       = out_load && !buf_empty;
assign bypass    = out_load && buf_empty && push;   // Straight to the output stage
assign wr_en     = push && !bypass;
assign empty     = buf_empty && !out_tvalid;

always_ff @(posedge clk)
begin
	if (wr_en)
		mem[wr_ptr] <= push_data;
end

always_ff @(posedge clk)
begin
	if (pop)
		out_tdata <= mem[rd_ptr];
	else if (bypass)
		out_tdata <= push_data;
end

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		wr_ptr     <= '0;
		rd_ptr     <= '0;
		count      <= '0;
		out_tvalid <= 1'b0;
	end
	else
	begin
		if (wr_en)
			wr_ptr <= wr_ptr + 1'b1;
		if (pop)
			rd_ptr <= rd_ptr + 1'b1;
		if (wr_en && !pop)
			count <= count + 1'b1;
		else if (pop && !wr_en)
			count <= count - 1'b1;
		if (out_load)
			out_tvalid <= pop || bypass;
	end
end

// Nobody looks at a ready on the push side
a_no_overflow: assert property (@(posedge clk) disable iff (!sresetn)
	push |-> (count != FULL_COUNT) || pop);

endmodule

`default_nettype wire

/* source/serial_wb_ctrl.sv */
`default_nettype none

module serial_wb_ctrl (
	input  logic                 clk,
	input  logic                 sresetn,

	// Command and write data stream
	input  logic                 in_tvalid,
	output logic                 in_tready,
	input  serial_wb_pkg::byte_t in_tdata,

	// Wishbone master side
	output logic                 wb_cyc,
	output logic                 wb_stb,
	output logic                 wb_we,
	output wb_bus_pkg::data_t    wb_dat_m2s,
	input  logic                 wb_stall,
	input  logic                 wb_ack,

	// To the address tracker
	output logic                 beat_sent,
	output logic                 addr_load,
	output wb_bus_pkg::addr_t    addr_byte,
	output logic                 auto_inc,
	input  logic                 outstanding_zero,

	// Read return FIFO
	input  logic                 fifo_empty,
	output logic                 fifo_push
);
import serial_wb_pkg::*;

ctrl_state_t state;
count_t      beats_left;
logic        hdr_take;

assign hdr_take = in_tvalid && in_tready;

always_ff @(posedge clk)
begin
	if (!sresetn)
	begin
		state    <= GET_OP;
		wb_we    <= 1'b0;
		auto_inc <= 1'b0;
	end
	else
	begin
		case (state)
			GET_OP:
			begin
				if (hdr_take)
				begin
					wb_we    <= in_tdata[OP_WE_BIT];
					auto_inc <= in_tdata[OP_INC_BIT];
					state    <= GET_ADDR;
				end
			end
			GET_ADDR:
			begin
				if (hdr_take)
					state <= GET_COUNT;   // Address goes to the tracker
			end
			GET_COUNT:
			begin
				if (hdr_take)
					state <= BUS_ACTIVE;
			end
			BUS_ACTIVE:
			begin
				if (beat_sent && beats_left == count_t'(1))
					state <= LAST_ACK;
			end
			LAST_ACK:
			begin
				// Read data must have left the bridge as well
				if (outstanding_zero && fifo_empty)
					state <= GET_OP;
			end
			default: state <= GET_OP;
		endcase
	end
end

// Beat counter
always_ff @(posedge clk)
begin
	if (state == GET_COUNT && hdr_take)
		beats_left <= {in_tdata == '0, in_tdata};   // 0 means 256
	else if (state == BUS_ACTIVE && beat_sent)
		beats_left <= beats_left - 1'b1;
end

// Strobe and input gating
always_comb
begin
	wb_stb    = 1'b0;
	in_tready = 1'b0;
	case (state)
		GET_OP, GET_ADDR, GET_COUNT: in_tready = 1'b1;
		BUS_ACTIVE:
		begin
			if (wb_we)
			begin
				// Write byte and bus beat move on the same edge
				wb_stb    = in_tvalid;
				in_tready = !wb_stall;
			end
			else
				wb_stb = 1'b1;
		end
		default: in_tready = 1'b0;   // LAST_ACK holds off the next command
	endcase
end

assign beat_sent  = wb_stb && !wb_stall;
assign wb_cyc     = (state == BUS_ACTIVE) || (state == LAST_ACK);
assign wb_dat_m2s = in_tdata;
assign addr_load  = (state == GET_ADDR) && hdr_take;
assign addr_byte  = in_tdata;
assign fifo_push  = wb_ack && !wb_we;   // Only read acks carry data

// A write byte taken from the stream must be counted as a beat
a_no_lost_write: assert property (@(posedge clk) disable iff (!sresetn)
	(state == BUS_ACTIVE && wb_we && in_tready && in_tvalid)
		|=> beats_left == $past(beats_left) - 1'b1);

a_state_legal: assert property (@(posedge clk) disable iff (!sresetn)
	state inside {GET_OP, GET_ADDR, GET_COUNT, BUS_ACTIVE, LAST_ACK});

endmodule

`default_nettype wire

/* source/serial_wb_pkg.sv */
`default_nettype none

// Command protocol of the serial stream
// A command is opcode, address, count, then one data byte per beat on writes
package serial_wb_pkg;

	typedef logic [7:0] byte_t;    // One stream byte

	// Beats left in a command, 1 to 256
	typedef logic [8:0] count_t;

	// Opcode byte fields
	localparam int OP_WE_BIT  = 0;   // Set for write
	localparam int OP_INC_BIT = 1;   // Set for address auto-increment

	// Controller states
	// GET_* take one header byte each, BUS_ACTIVE issues the beats,
	// LAST_ACK waits for the bus and the read FIFO to drain
	typedef enum logic [2:0]
	{
		GET_OP,
		GET_ADDR,
		GET_COUNT,
		BUS_ACTIVE,
		LAST_ACK
	} ctrl_state_t;

endpackage

`default_nettype wire

/* source/serial_wb_top.sv */
`default_nettype none

module serial_wb_top #(
	parameter int FIFO_DEPTH  = 256,   // Must hold all reads of one command
	parameter int ACK_LATENCY = 1
) (
	input  logic                 clk,
	input  logic                 sresetn,

	// Commands and write data
	input  logic                 in_tvalid,
	output logic                 in_tready,
	input  serial_wb_pkg::byte_t in_tdata,

	// Read data
	output logic                 out_tvalid,
	input  logic                 out_tready,
	output serial_wb_pkg::byte_t out_tdata,

	input  logic                 bus_hold
);
import wb_bus_pkg::*;

// Wishbone between the controller, tracker and RAM
logic  wb_cyc;
logic  wb_stb;
logic  wb_we;
addr_t wb_addr;
data_t wb_dat_m2s;
data_t wb_dat_s2m;
logic  wb_ack;
logic  wb_stall;

logic  beat_sent;
logic  addr_load;
addr_t addr_byte;
logic  auto_inc;
logic  outstanding_zero;
logic  fifo_push;
logic  fifo_empty;

serial_wb_ctrl i_ctrl (
	.clk              (clk),
	.sresetn          (sresetn),
	.in_tvalid        (in_tvalid),
	.in_tready        (in_tready),
	.in_tdata         (in_tdata),
	.wb_cyc           (wb_cyc),
	.wb_stb           (wb_stb),
	.wb_we            (wb_we),
	.wb_dat_m2s       (wb_dat_m2s),
	.wb_stall         (wb_stall),
	.wb_ack           (wb_ack),
	.beat_sent        (beat_sent),
	.addr_load        (addr_load),
	.addr_byte        (addr_byte),
	.auto_inc         (auto_inc),
	.outstanding_zero (outstanding_zero),
	.fifo_empty       (fifo_empty),
	.fifo_push        (fifo_push)
);

wb_addr_tracker i_tracker (
	.clk              (clk),
	.sresetn          (sresetn),
	.addr_load        (addr_load),
	.addr_byte        (addr_byte),
	.auto_inc         (auto_inc),
	.beat_sent        (beat_sent),
	.wb_ack           (wb_ack),
	.wb_addr          (wb_addr),
	.outstanding_zero (outstanding_zero)
);

axis_fifo #(
	.FIFO_DEPTH (FIFO_DEPTH)
) i_fifo (
	.clk        (clk),
	.sresetn    (sresetn),
	.push       (fifo_push),
	.push_data  (wb_dat_s2m),
	.out_tready (out_tready),
	.out_tvalid (out_tvalid),
	.out_tdata  (out_tdata),
	.empty      (fifo_empty)
);

wb_ram_slave #(
	.ACK_LATENCY (ACK_LATENCY)
) i_ram (
	.clk        (clk),
	.sresetn    (sresetn),
	.wb_cyc     (wb_cyc),
	.wb_stb     (wb_stb),
	.wb_we      (wb_we),
	.wb_addr    (wb_addr),
	.wb_dat_m2s (wb_dat_m2s),
	.bus_hold   (bus_hold),
	.wb_stall   (wb_stall),
	.wb_ack     (wb_ack),
	.wb_dat_s2m (wb_dat_s2m)
);

endmodule

`default_nettype wire

/* source/wb_addr_tracker.sv */
`default_nettype none

module wb_addr_tracker (
	input  logic              clk,
	input  logic              sresetn,

	input  logic              addr_load,   // Address header byte present
	input  wb_bus_pkg::addr_t addr_byte,
	input  logic              auto_inc,
	input  logic              beat_sent,
	input  logic              wb_ack,

	output wb_bus_pkg::addr_t wb_addr,
	output logic              outstanding_zero
);

// Beats issued and not yet acked, bounded by the slave ack latency
logic [3:0] outstanding;

// Start address, then one step per accepted beat
always_ff @(posedge clk)
begin
	if (addr_load)
		wb_addr <= addr_byte;
	else if (beat_sent && auto_inc)
		wb_addr <= wb_addr + 1'b1;   // Wraps at 255
end

always_ff @(posedge clk)
begin
	if (!sresetn)
		outstanding <= '0;
	else
	begin
		case ({beat_sent, wb_ack})
			2'b10: outstanding <= outstanding + 1'b1;
			2'b01: outstanding <= outstanding - 1'b1;
			default: outstanding <= outstanding;   // None or both
		endcase
	end
end

assign outstanding_zero = (outstanding == '0);

// Every ack belongs to an earlier beat
a_ack_expected: assert property (@(posedge clk) disable iff (!sresetn)
	wb_ack |-> !outstanding_zero);

// The controller only takes a new address once the previous command is done
a_load_idle: assert property (@(posedge clk) disable iff (!sresetn)
	addr_load |-> outstanding_zero);

endmodule

`default_nettype wire

/* source/wb_bus_pkg.sv */
`default_nettype none

// Bus-side definitions for the byte-wide Wishbone master, the RAM slave and the FIFO
package wb_bus_pkg;

	// One byte of data and one byte of address
	localparam int ADDR_W = 8;
	localparam int DATA_W = 8;

	// Every address decodes to a word in the RAM slave
	localparam int ADDR_SPACE = 2 ** ADDR_W;

	typedef logic [ADDR_W-1:0] addr_t;   // Bus address
	typedef logic [DATA_W-1:0] data_t;   // Bus data word

endpackage

`default_nettype wire

/* source/wb_ram_slave.sv */
`default_nettype none

module wb_ram_slave #(
	parameter int ACK_LATENCY = 1   // 1 to 3
) (
	input  logic              clk,
	input  logic              sresetn,

	input  logic              wb_cyc,
	input  logic              wb_stb,
	input  logic              wb_we,
	input  wb_bus_pkg::addr_t wb_addr,
	input  wb_bus_pkg::data_t wb_dat_m2s,

	input  logic              bus_hold,   // External stall source

	output logic              wb_stall,
	output logic              wb_ack,
	output wb_bus_pkg::data_t wb_dat_s2m
);
import wb_bus_pkg::*;

data_t                  mem [ADDR_SPACE];   // Contents survive reset
logic [ACK_LATENCY-1:0] ack_pipe;
data_t                  dat_pipe [ACK_LATENCY];
logic                   accept;

if (ACK_LATENCY < 1 || ACK_LATENCY > 3)
begin : g_bad_latency
	$error("wb_ram_slave ACK_LATENCY must be 1 to 3");
end

assign wb_stall = bus_hold;
assign accept   = wb_cyc && wb_stb && !wb_stall;

always_ff @(posedge clk)
begin
	if (accept && wb_we)
		mem[wb_addr] <= wb_dat_m2s;
end

// Read data rides along with the ack
always_ff @(posedge clk)
begin
	dat_pipe[0] <= mem[wb_addr];
	for (int i = 1; i < ACK_LATENCY; i++)
		dat_pipe[i] <= dat_pipe[i-1];
end

always_ff @(posedge clk)
begin
	if (!sresetn)
		ack_pipe <= '0;
	else
	begin
		ack_pipe[0] <= accept;   // Writes are acked too
		for (int i = 1; i < ACK_LATENCY; i++)
			ack_pipe[i] <= ack_pipe[i-1];
	end
end

assign wb_ack     = ack_pipe[ACK_LATENCY-1];
assign wb_dat_s2m = dat_pipe[ACK_LATENCY-1];

a_stb_in_cycle: assert property (@(posedge clk) disable iff (!sresetn)
	wb_stb |-> wb_cyc);

endmodule

`default_nettype wire
